//--- common/board_ctrl_if.sv
// --------------------------------------------------------------------------
// Board command and status bus between controller, board and output side
// --------------------------------------------------------------------------
`timescale 1ns/100ps

interface board_ctrl_if;
	import tetris_pkg::*;

	// Strobes from the controller
	logic     place;
	logic     clear;
	logic     wipe;
	// Board status levels
	logic     any_full;
	logic     overflow;
	visible_t visible;

	modport ctrl (output place, output clear, output wipe, input any_full, input overflow);

	modport board (
		input place, input clear, input wipe,
		output any_full, output overflow, output visible
	);

	modport monitor (input visible, input overflow);

endinterface

//--- common/piece_if.sv
// --------------------------------------------------------------------------
// Latched piece from intake to board and controller
// --------------------------------------------------------------------------
`timescale 1ns/100ps

interface piece_if;
	import tetris_pkg::*;

	shape_e   shape;
	col_idx_t column;
	// Sixteenth piece of the game
	logic     last;
	logic     pending;

	modport source (output shape, output column, output last, output pending);

	modport sink (input shape, input column);

	modport ctrl (input pending, input last);

endinterface

//--- common/tetris_pkg.sv
// --------------------------------------------------------------------------
// Tetris engine package
// Board geometry, piece footprints, controller states and shared types
// --------------------------------------------------------------------------
package tetris_pkg;

	// ------------------------------------------------------------------------
	// Board geometry
	// ------------------------------------------------------------------------
	localparam int BOARD_COLS      = 6;
	localparam int VISIBLE_ROWS    = 12;
	localparam int TOTAL_ROWS      = 14;
	localparam int ROW_W           = 4;
	localparam int PIECES_PER_GAME = 16;
	localparam int CNT_W           = $clog2(PIECES_PER_GAME);
	localparam int SCORE_W         = 4;
	localparam int CELLS_PER_PIECE = 4;
	localparam int SHAPE_COUNT     = 8;

	// Bit index of a row equals the column
	typedef logic [BOARD_COLS-1:0] board_row_t;
	typedef board_row_t [TOTAL_ROWS-1:0] board_t;
	typedef board_row_t [VISIBLE_ROWS-1:0] visible_t;
	typedef logic [ROW_W-1:0] row_idx_t;
	typedef logic [2:0] col_idx_t;
	typedef logic [CNT_W-1:0] piece_cnt_t;
	typedef logic [SCORE_W-1:0] score_t;

	localparam piece_cnt_t LAST_PIECE = piece_cnt_t'(PIECES_PER_GAME - 1);

	typedef enum logic [2:0] {
		SHAPE_O      = 3'd0,
		SHAPE_I_VERT = 3'd1,
		SHAPE_I_HORZ = 3'd2,
		SHAPE_J_TALL = 3'd3,
		SHAPE_J_WIDE = 3'd4,
		SHAPE_L_TALL = 3'd5,
		SHAPE_S_TALL = 3'd6,
		SHAPE_Z_WIDE = 3'd7
	} shape_e;

	// ------------------------------------------------------------------------
	// Footprints
	// ------------------------------------------------------------------------
	// Base row sits one above the lowest row of the footprint
	typedef struct packed {
		logic [1:0]        col;
		logic signed [2:0] row;
	} shape_cell_t;

	localparam shape_cell_t shape_cells [SHAPE_COUNT][CELLS_PER_PIECE] = '{
		'{'{2'd0, -3'sd1}, '{2'd1, -3'sd1}, '{2'd0, 3'sd0}, '{2'd1, 3'sd0}},
		'{'{2'd0, -3'sd1}, '{2'd0, 3'sd0}, '{2'd0, 3'sd1}, '{2'd0, 3'sd2}},
		'{'{2'd0, -3'sd1}, '{2'd1, -3'sd1}, '{2'd2, -3'sd1}, '{2'd3, -3'sd1}},
		'{'{2'd1, -3'sd1}, '{2'd1, 3'sd0}, '{2'd1, 3'sd1}, '{2'd0, 3'sd1}},
		'{'{2'd0, -3'sd1}, '{2'd0, 3'sd0}, '{2'd1, 3'sd0}, '{2'd2, 3'sd0}},
		'{'{2'd0, -3'sd1}, '{2'd1, -3'sd1}, '{2'd0, 3'sd0}, '{2'd0, 3'sd1}},
		'{'{2'd1, -3'sd1}, '{2'd1, 3'sd0}, '{2'd0, 3'sd0}, '{2'd0, 3'sd1}},
		'{'{2'd0, -3'sd1}, '{2'd1, -3'sd1}, '{2'd1, 3'sd0}, '{2'd2, 3'sd0}}
	};

	typedef enum logic [2:0] {
		IDLE,
		PLACE,
		CLEAR,
		DONE,
		GAME_END
	} ctrl_state_e;

endpackage

//--- dv/tetris_ref_model.svh
// --------------------------------------------------------------------------
// Tetris reference model
// Board, landing, row clearing, score and game end for result prediction
// --------------------------------------------------------------------------
`ifndef TETRIS_REF_MODEL_SVH
`define TETRIS_REF_MODEL_SVH

localparam int BOARD_W     = 6;
localparam int SHOWN_ROWS  = 12;
localparam int MODEL_ROWS  = 14;
localparam int GAME_PIECES = 16;
localparam int SCORE_MOD   = 16;
localparam int PIECE_CELLS = 4;

bit [BOARD_W-1:0] model_board [MODEL_ROWS];
int               model_score;
int               model_count;

function automatic void model_reset();
	for (int r = 0; r < MODEL_ROWS; r++) begin
		model_board[r] = '0;
	end
	model_score = 0;
	model_count = 0;
endfunction

// Footprint width, for the legal column range
function automatic int shape_width(input int shape);
	int w;
	w = 0;
	for (int k = 0; k < PIECE_CELLS; k++) begin
		if (int'(shape_cells[shape][k].col) + 1 > w) begin
			w = int'(shape_cells[shape][k].col) + 1;
		end
	end
	return w;
endfunction

function automatic int model_height(input int c);
	int h;
	h = 0;
	for (int r = 0; r < SHOWN_ROWS; r++) begin
		if (model_board[r][c]) begin
			h = r + 1;
		end
	end
	return h;
endfunction

function automatic int lowest_full_row();
	for (int r = 0; r < SHOWN_ROWS; r++) begin
		if (&model_board[r]) begin
			return r;
		end
	end
	return -1;
endfunction

function automatic void model_remove_row(input int row);
	for (int r = row; r < MODEL_ROWS - 1; r++) begin
		model_board[r] = model_board[r + 1];
	end
	model_board[MODEL_ROWS - 1] = '0;
endfunction

// One piece through landing, clearing and game end
function automatic void model_place_piece(input int shape, input int col,
		output int exp_score, output bit exp_fail, output bit exp_end,
		output logic [71:0] exp_dump);
	int base;
	int cand;
	int c;
	int r;
	int row_off;
	bit over;
	base = 0;
	for (int k = 0; k < PIECE_CELLS; k++) begin
		c       = col + int'(shape_cells[shape][k].col);
		row_off = shape_cells[shape][k].row;
		cand    = model_height(c) - row_off;
		if (c < BOARD_W && cand > base) begin
			base = cand;
		end
	end
	for (int k = 0; k < PIECE_CELLS; k++) begin
		c       = col + int'(shape_cells[shape][k].col);
		row_off = shape_cells[shape][k].row;
		r       = base + row_off;
		// Cells above the top row are lost
		if (r >= 0 && r < MODEL_ROWS && c < BOARD_W) begin
			model_board[r][c] = 1'b1;
		end
	end
	r = lowest_full_row();
	while (r >= 0) begin
		model_remove_row(r);
		model_score = (model_score + 1) % SCORE_MOD;
		r = lowest_full_row();
	end
	model_count++;
	over      = (|model_board[SHOWN_ROWS]) || (|model_board[SHOWN_ROWS + 1]);
	exp_score = model_score;
	exp_fail  = over;
	exp_end   = over || (model_count == GAME_PIECES);
	exp_dump  = '0;
	if (exp_end) begin
		for (int rr = 0; rr < SHOWN_ROWS; rr++) begin
			for (int cc = 0; cc < BOARD_W; cc++) begin
				exp_dump[rr * BOARD_W + cc] = model_board[rr][cc];
			end
		end
		model_reset();
	end
endfunction

`endif

//--- dv/tetris_tb.sv
// --------------------------------------------------------------------------
// Tetris engine testbench
// Directed games checked against a reference board model
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module tetris_tb;
	import tetris_pkg::*;

	localparam int CLK_PERIOD     = 100;
	localparam int DRIVE_DELAY    = 10;
	localparam int RESET_CYCLES   = 8;
	localparam int RESULT_TIMEOUT = 200;
	localparam int RESET_COUNT    = 5;
	// Upper bound on pieces sent over all tests
	localparam int PIECE_BUDGET   = 54;
	localparam int WATCHDOG_NS    =
		(RESET_COUNT * RESET_CYCLES + PIECE_BUDGET * RESULT_TIMEOUT) * CLK_PERIOD;

	logic        clk;
	logic        rst_n;
	logic        in_valid;
	logic [2:0]  tetrominoes;
	logic [2:0]  position;
	logic        tetris_valid;
	logic        score_valid;
	logic        fail;
	logic [3:0]  score;
	logic [71:0] tetris;

	`include "tetris_ref_model.svh"

	tetris_top dut0 (
		.clk          (clk),
		.rst_n        (rst_n),
		.in_valid     (in_valid),
		.tetrominoes  (tetrominoes),
		.position     (position),
		.tetris_valid (tetris_valid),
		.score_valid  (score_valid),
		.fail         (fail),
		.score        (score),
		.tetris       (tetris)
	);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial begin
		#(WATCHDOG_NS);
		$display("DUT hung: run did not finish within %0d ns", WATCHDOG_NS);
		abort_run("watchdog expired");
	end

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------
	task automatic abort_run(input string reason);
		$display("TB FAILED");
		$fatal(1, "%s", reason);
	endtask

	task automatic check_value(input string test_name, input string what,
			input logic [71:0] exp, input logic [71:0] act);
		assert (act === exp) else begin
			$display("FAILED %s %s: expected %0h, actual %0h", test_name, what, exp, act);
			abort_run("output mismatch");
		end
	endtask

	task automatic apply_reset();
		@(posedge clk);
		#DRIVE_DELAY;
		rst_n    = 1'b0;
		in_valid = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		#DRIVE_DELAY;
		rst_n = 1'b1;
		model_reset();
	endtask

	task automatic wait_result(input string test_name);
		int cycles;
		cycles = 0;
		while (!score_valid) begin
			assert (!tetris_valid && !fail && score == 4'd0 && tetris == '0) else begin
				$display("%s: result outputs active outside the result cycle", test_name);
				abort_run("stray result output");
			end
			if (cycles == RESULT_TIMEOUT) begin
				$display("%s: DUT hung, no score_valid after %0d cycles", test_name, cycles);
				abort_run("result timeout");
			end
			@(posedge clk);
			#DRIVE_DELAY;
			cycles++;
		end
	endtask

	// Sends one piece and checks the result against the model
	task automatic drop_piece(input string test_name, input int shape, input int col,
			output bit ended, output int got_score, output bit got_fail);
		int          exp_score;
		bit          exp_fail;
		bit          exp_end;
		logic [71:0] exp_dump;
		model_place_piece(shape, col, exp_score, exp_fail, exp_end, exp_dump);
		@(posedge clk);
		#DRIVE_DELAY;
		in_valid    = 1'b1;
		tetrominoes = 3'(shape);
		position    = 3'(col);
		@(posedge clk);
		#DRIVE_DELAY;
		in_valid = 1'b0;
		wait_result(test_name);
		check_value(test_name, "score", exp_score, score);
		check_value(test_name, "tetris_valid", exp_end, tetris_valid);
		check_value(test_name, "fail", exp_fail, fail);
		check_value(test_name, "tetris", exp_dump, tetris);
		ended     = tetris_valid;
		got_score = score;
		got_fail  = fail;
	endtask

	// ------------------------------------------------------------------------
	// Tests
	// ------------------------------------------------------------------------
	task automatic reset_state();
		bit ended;
		int got_score;
		bit got_fail;
		apply_reset();
		check_value("reset_state", "score_valid", 0, score_valid);
		check_value("reset_state", "tetris_valid", 0, tetris_valid);
		check_value("reset_state", "fail", 0, fail);
		check_value("reset_state", "score", 0, score);
		check_value("reset_state", "tetris", 0, tetris);
		drop_piece("reset_state", SHAPE_O, 0, ended, got_score, got_fail);
		check_value("reset_state", "first score", 0, got_score);
		drop_piece("reset_state", SHAPE_I_VERT, 5, ended, got_score, got_fail);
		check_value("reset_state", "second score", 0, got_score);
		check_value("reset_state", "game end", 0, ended);
	endtask

	task automatic each_shape_lands();
		bit ended;
		bit game_over;
		int got_score;
		bit got_fail;
		int col;
		int filler;
		apply_reset();
		game_over = 1'b0;
		// Uneven stack first
		drop_piece("each_shape_lands", SHAPE_I_VERT, 0, ended, got_score, got_fail);
		drop_piece("each_shape_lands", SHAPE_O, 3, ended, got_score, got_fail);
		for (int s = 0; s < 8; s++) begin
			col = (s * 2 + 1) % (BOARD_W - shape_width(s) + 1);
			drop_piece("each_shape_lands", s, col, ended, got_score, got_fail);
			game_over = game_over || ended;
		end
		filler = 0;
		while (!game_over && filler < GAME_PIECES) begin
			drop_piece("each_shape_lands", SHAPE_O, (filler * 2) % BOARD_W,
				ended, got_score, got_fail);
			game_over = ended;
			filler++;
		end
		check_value("each_shape_lands", "board dumped", 1, game_over);
	endtask

	task automatic line_clear_score();
		int shapes [5]     = '{SHAPE_I_VERT, SHAPE_I_VERT, SHAPE_I_HORZ, SHAPE_O, SHAPE_O};
		int cols [5]       = '{4, 5, 0, 0, 2};
		int exp_scores [5] = '{0, 0, 1, 1, 3};
		bit ended;
		int got_score;
		bit got_fail;
		apply_reset();
		// One row on the third piece, two rows together on the fifth
		for (int i = 0; i < 5; i++) begin
			drop_piece("line_clear_score", shapes[i], cols[i], ended, got_score, got_fail);
			check_value("line_clear_score", "running score", exp_scores[i], got_score);
		end
	endtask

	task automatic overflow_fail();
		bit ended;
		int got_score;
		bit got_fail;
		int bars;
		apply_reset();
		// One cleared row first, so the next game has a score to restart
		drop_piece("overflow_fail", SHAPE_I_HORZ, 0, ended, got_score, got_fail);
		drop_piece("overflow_fail", SHAPE_O, 4, ended, got_score, got_fail);
		check_value("overflow_fail", "score before bars", 1, got_score);
		ended = 1'b0;
		bars  = 0;
		while (!ended && bars < 8) begin
			drop_piece("overflow_fail", SHAPE_I_VERT, 2, ended, got_score, got_fail);
			bars++;
		end
		check_value("overflow_fail", "tetris_valid", 1, ended);
		check_value("overflow_fail", "fail", 1, got_fail);
		drop_piece("overflow_fail", SHAPE_O, 0, ended, got_score, got_fail);
		check_value("overflow_fail", "new game score", 0, got_score);
	endtask

	task automatic sixteen_piece_game();
		bit ended;
		int got_score;
		bit got_fail;
		int shape;
		int col;
		int sent;
		apply_reset();
		ended = 1'b0;
		sent  = 0;
		while (!ended && sent < GAME_PIECES) begin
			shape = $urandom % 8;
			col   = $urandom % (BOARD_W - shape_width(shape) + 1);
			drop_piece("sixteen_piece_game", shape, col, ended, got_score, got_fail);
			sent++;
		end
		check_value("sixteen_piece_game", "game end", 1, ended);
	endtask

	initial begin
		rst_n       = 1'b0;
		in_valid    = 1'b0;
		tetrominoes = 3'd0;
		position    = 3'd0;
		void'($urandom(32'h1c266534));
		model_reset();
		reset_state();
		each_shape_lands();
		line_clear_score();
		overflow_fail();
		sixteen_piece_game();
		$display("TB PASSED");
		$finish;
	end

endmodule

//--- hw/board/board_store.sv
// --------------------------------------------------------------------------
// Board register
// Places pieces, removes the lowest full row, wipes at end of game
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module board_store (
	input  logic        clk,
	input  logic        rst_n,
	piece_if.sink       piece,
	board_ctrl_if.board ctrl
);
	import tetris_pkg::*;

	board_t                    board;
	board_t                    placed;
	board_t                    shifted;
	board_t                    cleared_board;
	row_idx_t                  base_row;
	row_idx_t                  low_row;
	logic [VISIBLE_ROWS-1:0]   full_rows;
	logic signed [ROW_W:0]     cell_row;
	logic [$bits(col_idx_t):0] cell_col;

	landing_calc u_landing (
		.board    (board),
		.shape    (piece.shape),
		.column   (piece.column),
		.base_row (base_row)
	);

	// ------------------------------------------------------------------------
	// Placement
	// ------------------------------------------------------------------------
	always_comb begin
		placed   = board;
		cell_row = '0;
		cell_col = '0;
		for (int k = 0; k < CELLS_PER_PIECE; k++) begin
			cell_row = $signed({1'b0, base_row}) + shape_cells[piece.shape][k].row;
			cell_col = {1'b0, piece.column} + shape_cells[piece.shape][k].col;
			// Cells above the top overflow row are lost
			if (cell_row >= 0 && cell_row < TOTAL_ROWS && cell_col < BOARD_COLS) begin
				placed[cell_row[ROW_W-1:0]][cell_col[2:0]] = 1'b1;
			end
		end
	end

	// ------------------------------------------------------------------------
	// Row removal
	// ------------------------------------------------------------------------
	always_comb begin
		for (int r = 0; r < VISIBLE_ROWS; r++) begin
			full_rows[r] = &board[r];
		end
		low_row = '0;
		for (int r = VISIBLE_ROWS - 1; r >= 0; r--) begin
			if (full_rows[r]) begin
				low_row = row_idx_t'(r);
			end
		end
	end

	assign shifted = {board_row_t'('0), board[TOTAL_ROWS-1:1]};

	always_comb begin
		for (int r = 0; r < TOTAL_ROWS; r++) begin
			cleared_board[r] = (r < low_row) ? board[r] : shifted[r];
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			board <= '0;
		end else if (ctrl.wipe) begin
			board <= '0;
		end else if (ctrl.place) begin
			board <= placed;
		end else if (ctrl.clear) begin
			board <= cleared_board;
		end
	end

	assign ctrl.any_full = |full_rows;
	assign ctrl.overflow = |board[TOTAL_ROWS-1:VISIBLE_ROWS];
	assign ctrl.visible  = board[VISIBLE_ROWS-1:0];

	a_place_clear_exclusive : assert property (@(posedge clk) disable iff (!rst_n)
		!(ctrl.place && ctrl.clear))
		else $error("place and clear issued together");

endmodule

//--- hw/board/landing_calc.sv
// --------------------------------------------------------------------------
// Landing calculation
// Column heights against the piece footprint give the landing base row
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module landing_calc (
	input  tetris_pkg::board_t   board,
	input  tetris_pkg::shape_e   shape,
	input  tetris_pkg::col_idx_t column,
	output tetris_pkg::row_idx_t base_row
);
	import tetris_pkg::*;

	row_idx_t                height [BOARD_COLS];
	logic [$bits(col_idx_t):0] cell_col;
	logic signed [ROW_W:0]   cand;
	logic signed [ROW_W:0]   best;

	// Height is one above the highest filled visible cell
	always_comb begin
		for (int c = 0; c < BOARD_COLS; c++) begin
			height[c] = '0;
			for (int r = 0; r < VISIBLE_ROWS; r++) begin
				if (board[r][c]) begin
					height[c] = row_idx_t'(r + 1);
				end
			end
		end
	end

	// Highest requirement over all footprint cells wins
	always_comb begin
		best     = '0;
		cell_col = '0;
		cand     = '0;
		for (int k = 0; k < CELLS_PER_PIECE; k++) begin
			cell_col = {1'b0, column} + shape_cells[shape][k].col;
			if (cell_col < BOARD_COLS) begin
				cand = $signed({1'b0, height[cell_col[2:0]]}) - shape_cells[shape][k].row;
				if (cand > best) begin
					best = cand;
				end
			end
		end
	end

	assign base_row = row_idx_t'(best);

endmodule

//--- hw/game_ctrl.sv
// --------------------------------------------------------------------------
// Game controller
// Sequences placement, row clearing, result and end of game
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module game_ctrl (
	input  logic       clk,
	input  logic       rst_n,
	piece_if.ctrl      piece,
	board_ctrl_if.ctrl ctrl,
	output logic       cleared,
	output logic       done,
	output logic       game_end
);
	import tetris_pkg::*;

	ctrl_state_e state;
	ctrl_state_e state_next;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			state <= state_next;
		end
	end

	always_comb begin
		state_next = state;
		case (state)
			IDLE: begin
				if (piece.pending) begin
					state_next = PLACE;
				end
			end
			PLACE: state_next = CLEAR;
			CLEAR: begin
				// One full row removed per cycle
				if (!ctrl.any_full) begin
					state_next = (ctrl.overflow || piece.last) ? GAME_END : DONE;
				end
			end
			DONE:     state_next = IDLE;
			GAME_END: state_next = IDLE;
			default:  state_next = IDLE;
		endcase
	end

	assign cleared    = (state == CLEAR) && ctrl.any_full;
	assign done       = (state == DONE);
	assign game_end   = (state == GAME_END);
	assign ctrl.place = (state == PLACE);
	assign ctrl.clear = cleared;
	assign ctrl.wipe  = game_end;

	// A result retires a pending piece on a board with no full row
	a_finish_clean : assert property (@(posedge clk) disable iff (!rst_n)
		(done || game_end) |-> piece.pending && !ctrl.any_full)
		else $error("result reported without a pending piece or with full rows left");

endmodule

//--- hw/piece_intake.sv
// --------------------------------------------------------------------------
// Piece intake
// Latches shape and column, counts pieces and flags the last one of a game
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module piece_intake (
	input  logic       clk,
	input  logic       rst_n,
	input  logic       in_valid,
	input  logic [2:0] tetrominoes,
	input  logic [2:0] position,
	input  logic       done,
	input  logic       game_end,
	piece_if.source    piece
);
	import tetris_pkg::*;

	piece_cnt_t count;
	logic       accept;

	assign accept = in_valid && !piece.pending;

	always_ff @(posedge clk) begin
		if (accept) begin
			piece.shape  <= shape_e'(tetrominoes);
			piece.column <= col_idx_t'(position);
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			piece.pending <= 1'b0;
			piece.last    <= 1'b0;
			count         <= '0;
		end else if (game_end) begin
			piece.pending <= 1'b0;
			piece.last    <= 1'b0;
			count         <= '0;
		end else if (done) begin
			piece.pending <= 1'b0;
		end else if (accept) begin
			piece.pending <= 1'b1;
			piece.last    <= (count == LAST_PIECE);
			count         <= count + 1'b1;
		end
	end

	// Sender waits for the result before the next piece
	a_no_early_piece : assert property (@(posedge clk) disable iff (!rst_n)
		in_valid |-> !piece.pending)
		else $error("in_valid while a piece is still in flight");

endmodule

//--- hw/result_output.sv
// --------------------------------------------------------------------------
// Result output
// Score counter and registered result ports
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module result_output (
	input  logic                 clk,
	input  logic                 rst_n,
	input  logic                 cleared,
	input  logic                 done,
	input  logic                 game_end,
	board_ctrl_if.monitor        status,
	output logic                 score_valid,
	output logic                 tetris_valid,
	output logic                 fail,
	output tetris_pkg::score_t   score,
	output tetris_pkg::visible_t tetris
);
	import tetris_pkg::*;

	score_t score_cnt;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			score_cnt <= '0;
		end else if (game_end) begin
			score_cnt <= '0;
		end else if (cleared) begin
			score_cnt <= score_cnt + 1'b1;
		end
	end

	// Ports stay zero outside the result cycle
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			score_valid  <= 1'b0;
			tetris_valid <= 1'b0;
			fail         <= 1'b0;
			score        <= '0;
			tetris       <= '0;
		end else begin
			score_valid  <= done || game_end;
			tetris_valid <= game_end;
			fail         <= game_end && status.overflow;
			score        <= (done || game_end) ? score_cnt : '0;
			tetris       <= game_end ? status.visible : '0;
		end
	end

	// A plain result never hides an overflowed board
	a_no_hidden_fail : assert property (@(posedge clk) disable iff (!rst_n)
		done |-> !status.overflow)
		else $error("overflowed board reported without fail");

endmodule

//--- hw/tetris_top.sv
// --------------------------------------------------------------------------
// Tetris engine top level
// Drops pieces on a 6x12 board, clears full rows, reports score and board
// --------------------------------------------------------------------------
`timescale 1ns/100ps

module tetris_top (
	input  logic        clk,
	input  logic        rst_n,
	input  logic        in_valid,
	input  logic [2:0]  tetrominoes,
	input  logic [2:0]  position,
	output logic        tetris_valid,
	output logic        score_valid,
	output logic        fail,
	output logic [3:0]  score,
	output logic [71:0] tetris
);

	logic cleared;
	logic done;
	logic game_end;

	piece_if      piece_bus ();
	board_ctrl_if board_bus ();

	piece_intake u_intake (
		.clk         (clk),
		.rst_n       (rst_n),
		.in_valid    (in_valid),
		.tetrominoes (tetrominoes),
		.position    (position),
		.done        (done),
		.game_end    (game_end),
		.piece       (piece_bus.source)
	);

	board_store u_board (
		.clk   (clk),
		.rst_n (rst_n),
		.piece (piece_bus.sink),
		.ctrl  (board_bus.board)
	);

	game_ctrl u_ctrl (
		.clk      (clk),
		.rst_n    (rst_n),
		.piece    (piece_bus.ctrl),
		.ctrl     (board_bus.ctrl),
		.cleared  (cleared),
		.done     (done),
		.game_end (game_end)
	);

	result_output u_result (
		.clk          (clk),
		.rst_n        (rst_n),
		.cleared      (cleared),
		.done         (done),
		.game_end     (game_end),
		.status       (board_bus.monitor),
		.score_valid  (score_valid),
		.tetris_valid (tetris_valid),
		.fail         (fail),
		.score        (score),
		.tetris       (tetris)
	);

endmodule

//--- project.f
common/tetris_pkg.sv
common/board_ctrl_if.sv
common/piece_if.sv
hw/piece_intake.sv
hw/board/landing_calc.sv
hw/board/board_store.sv
hw/game_ctrl.sv
hw/result_output.sv
hw/tetris_top.sv
+incdir+dv
dv/tetris_tb.sv
